//--- tb.f
+incdir+verif
src/cpu_pkg.sv
src/lane_if.sv
src/instr_decoder.sv
src/register_file.sv
src/decode_stage.sv
src/execute_lane.sv
src/dual_issue_core.sv
verif/core_props.sv
verif/tb_top.sv

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_top -o tb_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator compile failed with status $status"
  exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TESTS PASSED" sim.log; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed, see sim.log"
exit 1

//--- verif/ref_model.svh
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

// architectural state in program order
logic [31:0] model_regs [32];
int          dep_cnt;

typedef struct {
  logic [4:0]  dest;
  logic [31:0] data;
  int          cycle;
} exp_t;

exp_t exp_q0 [$];
exp_t exp_q1 [$];

function automatic logic [4:0] dest_of(cpu_pkg::instr_u w);
  if (w.r.opcode == cpu_pkg::op_rtype) begin
    return w.r.rd;
  end
  return w.i.rt;
endfunction

// rt is a source only for r-type
function automatic bit reads_reg(cpu_pkg::instr_u w, logic [4:0] r);
  if (w.r.opcode == cpu_pkg::op_rtype) begin
    return (w.r.rs == r) || (w.r.rt == r);
  end
  return w.i.rs == r;
endfunction

function automatic bit pair_dependent(cpu_pkg::instr_u w0, cpu_pkg::instr_u w1);
  logic [4:0] d0;
  d0 = dest_of(w0);
  return (d0 != 5'd0) && reads_reg(w1, d0);
endfunction

function automatic logic [31:0] result_of(cpu_pkg::instr_u w);
  logic [31:0] a;
  logic [31:0] b;
  a = model_regs[w.r.rs];
  b = model_regs[w.r.rt];
  case (w.r.opcode)
    cpu_pkg::op_rtype: begin
      case (w.r.funct)
        cpu_pkg::fn_add: return a + b;
        cpu_pkg::fn_sub: return a - b;
        cpu_pkg::fn_and: return a & b;
        cpu_pkg::fn_or:  return a | b;
        cpu_pkg::fn_xor: return a ^ b;
        cpu_pkg::fn_slt: return {31'd0, $signed(a) < $signed(b)};
        default:         return 32'd0;
      endcase
    end
    cpu_pkg::op_addi: return a + {{16{w.i.imm[15]}}, w.i.imm};
    cpu_pkg::op_andi: return a & {16'd0, w.i.imm};
    cpu_pkg::op_ori:  return a | {16'd0, w.i.imm};
    default:          return 32'd0;
  endcase
endfunction

// lane 0 runs before lane 1 of a pair taken at edge n
task automatic accept_pair(cpu_pkg::instr_u w0, cpu_pkg::instr_u w1, int n);
  exp_t e;
  bit   dep;
  dep = pair_dependent(w0, w1);
  e.dest = dest_of(w0);
  e.data = result_of(w0);
  e.cycle = n + 2;
  if (e.dest != 5'd0) begin
    model_regs[e.dest] = e.data;
    exp_q0.push_back(e);
  end
  e.dest = dest_of(w1);
  e.data = result_of(w1);
  e.cycle = dep ? n + 3 : n + 2;
  if (e.dest != 5'd0) begin
    model_regs[e.dest] = e.data;
    exp_q1.push_back(e);
  end
  if (dep) begin
    dep_cnt++;
  end
endtask

`endif

//--- verif/tb_top.sv
`timescale 1ns/10ps

module tb_top;

  localparam int total_pairs = 316;

  logic            clk;
  logic            arst_n;
  logic            issue_valid;
  cpu_pkg::instr_u issue_inst0;
  cpu_pkg::instr_u issue_inst1;
  logic            issue_ready;
  logic            wb_valid0;
  logic [4:0]      wb_dest0;
  logic [31:0]     wb_data0;
  logic            wb_valid1;
  logic [4:0]      wb_dest1;
  logic [31:0]     wb_data1;

  int seed = 32'h1c2a;
  int cycle_cnt;
  int low_cnt;
  int errors;
  int checks;

  `include "ref_model.svh"

  dual_issue_core u_dual_issue_core (.*);

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  //////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////

  function automatic cpu_pkg::instr_u make_r(logic [5:0] fn, logic [4:0] rd, logic [4:0] rs,
                                             logic [4:0] rt);
    cpu_pkg::instr_u w;
    w.r.opcode = cpu_pkg::op_rtype;
    w.r.rs = rs;
    w.r.rt = rt;
    w.r.rd = rd;
    w.r.shamt = 5'd0;
    w.r.funct = fn;
    return w;
  endfunction

  function automatic cpu_pkg::instr_u make_i(logic [5:0] op, logic [4:0] rt, logic [4:0] rs,
                                             logic [15:0] imm);
    cpu_pkg::instr_u w;
    w.i.opcode = op;
    w.i.rs = rs;
    w.i.rt = rt;
    w.i.imm = imm;
    return w;
  endfunction

  // only r0..r7 so that hazards are frequent
  function automatic logic [4:0] rand_reg();
    return 5'({$random(seed)} % 8);
  endfunction

  function automatic cpu_pkg::instr_u rand_inst();
    logic [5:0]  fn_tab [6];
    int          k;
    logic [15:0] imm;
    fn_tab = '{cpu_pkg::fn_add, cpu_pkg::fn_sub, cpu_pkg::fn_and,
               cpu_pkg::fn_or, cpu_pkg::fn_xor, cpu_pkg::fn_slt};
    k = {$random(seed)} % 9;
    imm = 16'($random(seed));
    if (k < 6) return make_r(fn_tab[k], rand_reg(), rand_reg(), rand_reg());
    if (k == 6) return make_i(cpu_pkg::op_addi, rand_reg(), rand_reg(), imm);
    if (k == 7) return make_i(cpu_pkg::op_andi, rand_reg(), rand_reg(), imm);
    return make_i(cpu_pkg::op_ori, rand_reg(), rand_reg(), imm);
  endfunction

  task automatic issue_pair(cpu_pkg::instr_u w0, cpu_pkg::instr_u w1);
    bit taken;
    taken = 1'b0;
    issue_valid = 1'b1;
    issue_inst0 = w0;
    issue_inst1 = w1;
    while (!taken) begin
      @(negedge clk);
      if (issue_ready) begin
        taken = 1'b1;
        accept_pair(w0, w1, cycle_cnt + 1);
      end
      @(posedge clk);
      #2;
    end
    issue_valid = 1'b0;
  endtask

  task automatic idle(int n);
    repeat (n) begin
      @(posedge clk);
      #2;
    end
  endtask

  //////////////////////////////////////////////////
  // writeback checking
  //////////////////////////////////////////////////

  task automatic check_lane(int lane, logic v, logic [4:0] d, logic [31:0] data,
                            ref exp_t q[$]);
    exp_t e;
    if (v) begin
      checks++;
      assert (q.size() != 0) else begin
        $display("unexpected writeback on lane %0d to r%0d", lane, d);
        errors++;
      end
      if (q.size() != 0) begin
        e = q.pop_front();
        assert (d == e.dest) else begin
          $display("Mismatch wb_dest%0d exp %h got %h", lane, e.dest, d);
          errors++;
        end
        assert (data == e.data) else begin
          $display("Mismatch wb_data%0d exp %h got %h", lane, e.data, data);
          errors++;
        end
        assert (cycle_cnt == e.cycle) else begin
          $display("lane %0d result came at cycle %0d instead of cycle %0d",
                   lane, cycle_cnt, e.cycle);
          errors++;
        end
      end
    end else if (q.size() != 0) begin
      assert (q[0].cycle >= cycle_cnt) else begin
        $display("lane %0d result for r%0d never came", lane, q[0].dest);
        errors++;
        void'(q.pop_front());
      end
    end
  endtask

  always @(negedge clk) begin
    if (arst_n) begin
      check_lane(0, wb_valid0, wb_dest0, wb_data0, exp_q0);
      check_lane(1, wb_valid1, wb_dest1, wb_data1, exp_q1);
      if (!issue_ready) begin
        low_cnt++;
      end
    end
  end

  task automatic finish_test(int num, string name, int err0, int dep0, int low0);
    while (exp_q0.size() != 0 || exp_q1.size() != 0) begin
      @(negedge clk);
    end
    idle(3);
    // one stall cycle per split pair
    assert (low_cnt - low0 == dep_cnt - dep0) else begin
      $display("issue_ready low for %0d cycles, expected %0d", low_cnt - low0, dep_cnt - dep0);
      errors++;
    end
    if (errors == err0) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      $display("test %0d %s: %0d errors", num, name, errors - err0);
    end
  endtask

  //////////////////////////////////////////////////
  // watchdog
  //////////////////////////////////////////////////

  initial begin
    #((total_pairs * 4 + 100) * 20);
    $display("watchdog expired before all tests finished");
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    cpu_pkg::instr_u w0;
    cpu_pkg::instr_u w1;
    int              e0;
    int              d0;
    int              l0;
    clk = 1'b0;
    arst_n = 1'b0;
    issue_valid = 1'b0;
    issue_inst0 = '0;
    issue_inst1 = '0;
    low_cnt = 0;
    errors = 0;
    checks = 0;
    dep_cnt = 0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = 32'd0;
    end
    repeat (10) @(posedge clk);
    #2;
    arst_n = 1'b1;
    idle(2);

    // spaced independent pairs
    e0 = errors;
    d0 = dep_cnt;
    l0 = low_cnt;
    for (int i = 0; i < 40; i++) begin
      w0 = rand_inst();
      do w1 = rand_inst(); while (pair_dependent(w0, w1));
      issue_pair(w0, w1);
      idle(2);
    end
    finish_test(1, "independent pairs", e0, d0, l0);

    // back to back with hazards only across pairs
    e0 = errors;
    d0 = dep_cnt;
    l0 = low_cnt;
    for (int i = 0; i < 40; i++) begin
      w0 = rand_inst();
      do w1 = rand_inst(); while (pair_dependent(w0, w1));
      issue_pair(w0, w1);
    end
    finish_test(2, "forwarding and bypass", e0, d0, l0);

    e0 = errors;
    d0 = dep_cnt;
    l0 = low_cnt;
    for (int i = 0; i < 30; i++) begin
      do w0 = rand_inst(); while (dest_of(w0) == 5'd0);
      w1 = rand_inst();
      w1.r.rs = dest_of(w0);
      issue_pair(w0, w1);
    end
    finish_test(3, "dependent pairs", e0, d0, l0);

    e0 = errors;
    d0 = dep_cnt;
    l0 = low_cnt;
    issue_pair(make_i(cpu_pkg::op_addi, 5'd0, 5'd3, 16'h0055),
               make_r(cpu_pkg::fn_add, 5'd0, 5'd1, 5'd2));
    issue_pair(make_r(cpu_pkg::fn_add, 5'd5, 5'd0, 5'd0),
               make_i(cpu_pkg::op_ori, 5'd6, 5'd0, 16'h0012));
    finish_test(4, "writes to r0", e0, d0, l0);

    // both lanes write the same destination
    e0 = errors;
    d0 = dep_cnt;
    l0 = low_cnt;
    for (int i = 0; i < 2; i++) begin
      issue_pair(make_i(cpu_pkg::op_addi, 5'd3, 5'd1, 16'($random(seed))),
                 make_i(cpu_pkg::op_addi, 5'd3, 5'd2, 16'($random(seed))));
      issue_pair(make_r(cpu_pkg::fn_add, 5'd4, 5'd3, 5'd0),
                 make_r(cpu_pkg::fn_or, 5'd5, 5'd3, 5'd3));
    end
    finish_test(5, "same destination", e0, d0, l0);

    e0 = errors;
    d0 = dep_cnt;
    l0 = low_cnt;
    for (int i = 0; i < 200; i++) begin
      issue_pair(rand_inst(), rand_inst());
      if ({$random(seed)} % 3 == 0) begin
        idle(1);
      end
    end
    finish_test(6, "random mix", e0, d0, l0);

    $display("tests run 6, writebacks checked %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- verif/core_props.sv
`timescale 1ns/10ps

module core_props (
  input logic       clk,
  input logic       arst_n,
  input logic       issue_ready,
  input logic       wb_valid0,
  input logic [4:0] wb_dest0,
  input logic       wb_valid1,
  input logic [4:0] wb_dest1
);

  // r0 is never a visible destination
  a_wb0_not_r0: assert property (@(posedge clk) disable iff (!arst_n)
    wb_valid0 |-> wb_dest0 != 5'd0) else $error("lane 0 wrote r0");
  a_wb1_not_r0: assert property (@(posedge clk) disable iff (!arst_n)
    wb_valid1 |-> wb_dest1 != 5'd0) else $error("lane 1 wrote r0");

  a_ready_after_reset: assert property (@(posedge clk)
    $rose(arst_n) |-> issue_ready) else $error("issue_ready low after reset");

  // a split takes one cycle
  a_short_stall: assert property (@(posedge clk) disable iff (!arst_n)
    !issue_ready |=> issue_ready) else $error("issue_ready low two cycles in a row");

endmodule

bind dual_issue_core core_props u_core_props (.*);

//--- src/dual_issue_core.sv
`timescale 1ns/10ps

module dual_issue_core (
  input  logic                               clk,
  input  logic                               arst_n,
  input  logic                               issue_valid,
  input  cpu_pkg::instr_u                    issue_inst0,
  input  cpu_pkg::instr_u                    issue_inst1,
  output logic                               issue_ready,
  output logic                               wb_valid0,
  output logic [cpu_pkg::reg_addr_width-1:0] wb_dest0,
  output logic [cpu_pkg::data_width-1:0]     wb_data0,
  output logic                               wb_valid1,
  output logic [cpu_pkg::reg_addr_width-1:0] wb_dest1,
  output logic [cpu_pkg::data_width-1:0]     wb_data1
);

  lane_bus lane0_bus ();
  lane_bus lane1_bus ();
  wb_bus   wb0_bus ();
  wb_bus   wb1_bus ();

  decode_stage u_decode_stage (
    .clk         (clk),
    .arst_n      (arst_n),
    .issue_valid (issue_valid),
    .issue_inst0 (issue_inst0),
    .issue_inst1 (issue_inst1),
    .issue_ready (issue_ready),
    .wb0         (wb0_bus),
    .wb1         (wb1_bus),
    .lane0       (lane0_bus),
    .lane1       (lane1_bus)
  );

  //////////////////////////////////////////////////
  // execute lanes
  //////////////////////////////////////////////////

  execute_lane #(.own_is_lane1(1'b0)) u_exec0 (
    .clk      (clk),
    .arst_n   (arst_n),
    .dec      (lane0_bus),
    .own_wb   (wb0_bus),
    .other_wb (wb1_bus)
  );

  execute_lane #(.own_is_lane1(1'b1)) u_exec1 (
    .clk      (clk),
    .arst_n   (arst_n),
    .dec      (lane1_bus),
    .own_wb   (wb1_bus),
    .other_wb (wb0_bus)
  );

  assign wb_valid0 = wb0_bus.valid;
  assign wb_dest0  = wb0_bus.dest;
  assign wb_data0  = wb0_bus.data;
  assign wb_valid1 = wb1_bus.valid;
  assign wb_dest1  = wb1_bus.dest;
  assign wb_data1  = wb1_bus.data;

endmodule

//--- src/execute_lane.sv
`timescale 1ns/10ps

module execute_lane #(
  parameter bit own_is_lane1 = 1'b0
) (
  input  logic      clk,
  input  logic      arst_n,
  lane_bus.execute  dec,
  wb_bus.source     own_wb,
  wb_bus.sink       other_wb
);

  localparam int dw = cpu_pkg::data_width;
  localparam int aw = cpu_pkg::reg_addr_width;

  logic             ex_valid;
  logic [aw-1:0]    ex_dest;
  logic [aw-1:0]    ex_src_a;
  logic [aw-1:0]    ex_src_b;
  logic [dw-1:0]    ex_opnd_a;
  logic [dw-1:0]    ex_opnd_b;
  logic             ex_use_imm;
  logic [dw-1:0]    ex_imm;
  cpu_pkg::alu_op_e ex_alu_op;

  logic             wb_valid_q;
  logic [aw-1:0]    wb_dest_q;
  logic [dw-1:0]    wb_data_q;

  logic             hi_valid, lo_valid;
  logic [aw-1:0]    hi_dest, lo_dest;
  logic [dw-1:0]    hi_data, lo_data;
  logic [dw-1:0]    opnd_a, opnd_b, alu_b, alu_result;

  // decode/execute register
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ex_valid <= 1'b0;
    end else begin
      ex_valid <= dec.valid;
    end
  end

  always_ff @(posedge clk) begin
    ex_dest    <= dec.dest;
    ex_src_a   <= dec.src_a;
    ex_src_b   <= dec.src_b;
    ex_opnd_a  <= dec.opnd_a;
    ex_opnd_b  <= dec.opnd_b;
    ex_use_imm <= dec.use_imm;
    ex_imm     <= dec.imm_value;
    ex_alu_op  <= dec.alu_op;
  end

  //////////////////////////////////////////////////
  // forwarding with lane 1 priority
  //////////////////////////////////////////////////

  assign hi_valid = own_is_lane1 ? wb_valid_q : other_wb.valid;
  assign hi_dest  = own_is_lane1 ? wb_dest_q  : other_wb.dest;
  assign hi_data  = own_is_lane1 ? wb_data_q  : other_wb.data;
  assign lo_valid = own_is_lane1 ? other_wb.valid : wb_valid_q;
  assign lo_dest  = own_is_lane1 ? other_wb.dest  : wb_dest_q;
  assign lo_data  = own_is_lane1 ? other_wb.data  : wb_data_q;

  always_comb begin
    opnd_a = ex_opnd_a;
    opnd_b = ex_opnd_b;
    if (lo_valid && (lo_dest == ex_src_a)) opnd_a = lo_data;
    if (hi_valid && (hi_dest == ex_src_a)) opnd_a = hi_data;
    if (lo_valid && (lo_dest == ex_src_b)) opnd_b = lo_data;
    if (hi_valid && (hi_dest == ex_src_b)) opnd_b = hi_data;
  end

  assign alu_b = ex_use_imm ? ex_imm : opnd_b;

  always_comb begin
    case (ex_alu_op)
      cpu_pkg::alu_add: alu_result = opnd_a + alu_b;
      cpu_pkg::alu_sub: alu_result = opnd_a - alu_b;
      cpu_pkg::alu_and: alu_result = opnd_a & alu_b;
      cpu_pkg::alu_or:  alu_result = opnd_a | alu_b;
      cpu_pkg::alu_xor: alu_result = opnd_a ^ alu_b;
      cpu_pkg::alu_slt: alu_result = {{(dw-1){1'b0}}, $signed(opnd_a) < $signed(alu_b)};
      default:          alu_result = '0;
    endcase
  end

  // execute/writeback register
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wb_valid_q <= 1'b0;
    end else begin
      wb_valid_q <= ex_valid;
    end
  end

  always_ff @(posedge clk) begin
    wb_dest_q <= ex_dest;
    wb_data_q <= alu_result;
  end

  assign own_wb.valid = wb_valid_q;
  assign own_wb.dest  = wb_dest_q;
  assign own_wb.data  = wb_data_q;

endmodule

//--- src/decode_stage.sv
`timescale 1ns/10ps

module decode_stage (
  input  logic            clk,
  input  logic            arst_n,
  input  logic            issue_valid,
  input  cpu_pkg::instr_u issue_inst0,
  input  cpu_pkg::instr_u issue_inst1,
  output logic            issue_ready,
  wb_bus.sink             wb0,
  wb_bus.sink             wb1,
  lane_bus.decode         lane0,
  lane_bus.decode         lane1
);

  logic [cpu_pkg::inst_width-1:0]     pair_word [2];
  logic [1:0]                         slot_valid;

  logic [1:0]                         dec_valid;
  logic [cpu_pkg::reg_addr_width-1:0] dec_dest [2];
  logic [cpu_pkg::reg_addr_width-1:0] dec_src_a [2];
  logic [cpu_pkg::reg_addr_width-1:0] dec_src_b [2];
  logic [1:0]                         dec_reads_b;
  logic [1:0]                         dec_use_imm;
  logic [cpu_pkg::data_width-1:0]     dec_imm [2];
  cpu_pkg::alu_op_e                   dec_alu_op [2];

  logic [1:0]                         writes;
  logic                               dependent;
  logic [cpu_pkg::reg_addr_width-1:0] rf_addr [4];
  logic [cpu_pkg::data_width-1:0]     rf_data [4];

  //////////////////////////////////////////////////
  // fetch/decode pair register
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      slot_valid <= 2'b00;
    end else if (issue_ready) begin
      slot_valid <= {2{issue_valid}};
    end else begin
      // on a split lane 0 leaves and lane 1 waits a cycle
      slot_valid[0] <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_valid && issue_ready) begin
      pair_word[0] <= issue_inst0;
      pair_word[1] <= issue_inst1;
    end
  end

  for (genvar k = 0; k < 2; k++) begin : g_dec
    instr_decoder u_instr_decoder (
      .inst      (pair_word[k]),
      .valid     (dec_valid[k]),
      .dest      (dec_dest[k]),
      .src_a     (dec_src_a[k]),
      .src_b     (dec_src_b[k]),
      .reads_b   (dec_reads_b[k]),
      .use_imm   (dec_use_imm[k]),
      .imm_value (dec_imm[k]),
      .alu_op    (dec_alu_op[k])
    );
    assign writes[k] = slot_valid[k] && dec_valid[k] && (dec_dest[k] != '0);
  end

  // lane 1 reads what lane 0 writes
  assign dependent = writes[0] && slot_valid[1] && dec_valid[1] &&
                     ((dec_src_a[1] == dec_dest[0]) ||
                      (dec_reads_b[1] && (dec_src_b[1] == dec_dest[0])));
  assign issue_ready = !dependent;

  assign rf_addr[0] = dec_src_a[0];
  assign rf_addr[1] = dec_src_b[0];
  assign rf_addr[2] = dec_src_a[1];
  assign rf_addr[3] = dec_src_b[1];

  register_file u_register_file (
    .clk     (clk),
    .arst_n  (arst_n),
    .wb0     (wb0),
    .wb1     (wb1),
    .rd_addr (rf_addr),
    .rd_data (rf_data)
  );

  //////////////////////////////////////////////////
  // lane buses
  //////////////////////////////////////////////////

  assign lane0.valid     = writes[0];
  assign lane0.dest      = dec_dest[0];
  assign lane0.src_a     = dec_src_a[0];
  assign lane0.src_b     = dec_src_b[0];
  assign lane0.opnd_a    = rf_data[0];
  assign lane0.opnd_b    = rf_data[1];
  assign lane0.use_imm   = dec_use_imm[0];
  assign lane0.imm_value = dec_imm[0];
  assign lane0.alu_op    = dec_alu_op[0];

  assign lane1.valid     = writes[1] && !dependent;
  assign lane1.dest      = dec_dest[1];
  assign lane1.src_a     = dec_src_a[1];
  assign lane1.src_b     = dec_src_b[1];
  assign lane1.opnd_a    = rf_data[2];
  assign lane1.opnd_b    = rf_data[3];
  assign lane1.use_imm   = dec_use_imm[1];
  assign lane1.imm_value = dec_imm[1];
  assign lane1.alu_op    = dec_alu_op[1];

endmodule

//--- src/register_file.sv
`timescale 1ns/10ps

module register_file (
  input  logic                               clk,
  input  logic                               arst_n,
  wb_bus.sink                                wb0,
  wb_bus.sink                                wb1,
  input  logic [cpu_pkg::reg_addr_width-1:0] rd_addr [4],
  output logic [cpu_pkg::data_width-1:0]     rd_data [4]
);

  localparam int num_regs = 2 ** cpu_pkg::reg_addr_width;

  logic [cpu_pkg::data_width-1:0] regs [num_regs];
  logic                           wr0;
  logic                           wr1;

  // r0 stays zero
  assign wr0 = wb0.valid && (wb0.dest != '0);
  assign wr1 = wb1.valid && (wb1.dest != '0);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (wr0) begin
        regs[wb0.dest] <= wb0.data;
      end
      // younger lane 1 write wins
      if (wr1) begin
        regs[wb1.dest] <= wb1.data;
      end
    end
  end

  //////////////////////////////////////////////////
  // read ports with write bypass
  //////////////////////////////////////////////////

  always_comb begin
    for (int p = 0; p < 4; p++) begin
      if (wr1 && (wb1.dest == rd_addr[p])) begin
        rd_data[p] = wb1.data;
      end else if (wr0 && (wb0.dest == rd_addr[p])) begin
        rd_data[p] = wb0.data;
      end else begin
        rd_data[p] = regs[rd_addr[p]];
      end
    end
  end

endmodule

//--- src/instr_decoder.sv
`timescale 1ns/10ps

module instr_decoder (
  input  cpu_pkg::instr_u                    inst,
  output logic                               valid,
  output logic [cpu_pkg::reg_addr_width-1:0] dest,
  output logic [cpu_pkg::reg_addr_width-1:0] src_a,
  output logic [cpu_pkg::reg_addr_width-1:0] src_b,
  output logic                               reads_b,
  output logic                               use_imm,
  output logic [cpu_pkg::data_width-1:0]     imm_value,
  output cpu_pkg::alu_op_e                   alu_op
);

  localparam int ext_width = cpu_pkg::data_width - 16;

  always_comb begin
    // i-type defaults
    valid     = 1'b1;
    dest      = inst.i.rt;
    src_a     = inst.i.rs;
    src_b     = inst.i.rt;
    reads_b   = 1'b0;
    use_imm   = 1'b1;
    imm_value = {{ext_width{inst.i.imm[15]}}, inst.i.imm};
    alu_op    = cpu_pkg::alu_add;

    case (inst.r.opcode)
      cpu_pkg::op_rtype: begin
        dest    = inst.r.rd;
        reads_b = 1'b1;
        use_imm = 1'b0;
        case (inst.r.funct)
          cpu_pkg::fn_add: alu_op = cpu_pkg::alu_add;
          cpu_pkg::fn_sub: alu_op = cpu_pkg::alu_sub;
          cpu_pkg::fn_and: alu_op = cpu_pkg::alu_and;
          cpu_pkg::fn_or:  alu_op = cpu_pkg::alu_or;
          cpu_pkg::fn_xor: alu_op = cpu_pkg::alu_xor;
          cpu_pkg::fn_slt: alu_op = cpu_pkg::alu_slt;
          default:         valid  = 1'b0;
        endcase
      end
      cpu_pkg::op_addi: begin
        alu_op = cpu_pkg::alu_add;
      end
      // logical immediates are zero extended
      cpu_pkg::op_andi: begin
        alu_op    = cpu_pkg::alu_and;
        imm_value = {{ext_width{1'b0}}, inst.i.imm};
      end
      cpu_pkg::op_ori: begin
        alu_op    = cpu_pkg::alu_or;
        imm_value = {{ext_width{1'b0}}, inst.i.imm};
      end
      default: begin
        valid = 1'b0;
      end
    endcase

    // unknown word writes nothing
    if (!valid) begin
      dest = '0;
    end
  end

endmodule

//--- src/lane_if.sv
`timescale 1ns/10ps

// decoded instruction from decode into one execute lane
interface lane_bus;
  logic                               valid;
  logic [cpu_pkg::reg_addr_width-1:0] dest;
  logic [cpu_pkg::reg_addr_width-1:0] src_a;
  logic [cpu_pkg::reg_addr_width-1:0] src_b;
  logic [cpu_pkg::data_width-1:0]     opnd_a;
  logic [cpu_pkg::data_width-1:0]     opnd_b;
  logic                               use_imm;
  logic [cpu_pkg::data_width-1:0]     imm_value;
  cpu_pkg::alu_op_e                   alu_op;

  modport decode (output valid, dest, src_a, src_b, opnd_a, opnd_b, use_imm, imm_value,
                  alu_op);
  modport execute (input valid, dest, src_a, src_b, opnd_a, opnd_b, use_imm, imm_value,
                   alu_op);
endinterface

// retired result of one lane
interface wb_bus;
  logic                               valid;
  logic [cpu_pkg::reg_addr_width-1:0] dest;
  logic [cpu_pkg::data_width-1:0]     data;

  modport source (output valid, dest, data);
  modport sink (input valid, dest, data);
endinterface

//--- src/cpu_pkg.sv
package cpu_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////

  localparam int data_width     = 32;
  localparam int inst_width     = 32;
  localparam int reg_addr_width = 5;

  //////////////////////////////////////////////////
  // opcodes and function codes
  //////////////////////////////////////////////////

  localparam logic [5:0] op_rtype = 6'h00;
  localparam logic [5:0] op_addi  = 6'h08;
  localparam logic [5:0] op_andi  = 6'h0c;
  localparam logic [5:0] op_ori   = 6'h0d;

  localparam logic [5:0] fn_add = 6'h20;
  localparam logic [5:0] fn_sub = 6'h22;
  localparam logic [5:0] fn_and = 6'h24;
  localparam logic [5:0] fn_or  = 6'h25;
  localparam logic [5:0] fn_xor = 6'h26;
  localparam logic [5:0] fn_slt = 6'h2a;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt
  } alu_op_e;

  //////////////////////////////////////////////////
  // instruction formats
  //////////////////////////////////////////////////

  typedef struct packed {
    logic [5:0]                opcode;
    logic [reg_addr_width-1:0] rs;
    logic [reg_addr_width-1:0] rt;
    logic [reg_addr_width-1:0] rd;
    logic [4:0]                shamt;
    logic [5:0]                funct;
  } r_format_t;

  typedef struct packed {
    logic [5:0]                opcode;
    logic [reg_addr_width-1:0] rs;
    logic [reg_addr_width-1:0] rt;
    logic [15:0]               imm;
  } i_format_t;

  // same word read two ways by opcode
  typedef union packed {
    r_format_t r;
    i_format_t i;
  } instr_u;

endpackage
